/* sources.f */
+incdir+.
char_pkg.sv
char_tile_if.sv
char_vram.sv
char_scan.sv
char_fetch.sv
char_shifter.sv
char_layer.sv
char_layer_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     = --binary --timing
TOP       = char_layer_tb
FILELIST  = sources.f
OBJ_DIR   = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* char_layer_tb.sv */
// ********************
// Character layer testbench
// Step table, ROM responder, pixel and scroll model
// ********************
`include "char_cfg.svh"

module char_layer_tb;

    localparam logic [2:0] K_FILL   = 3'd0;
    localparam logic [2:0] K_WRITE  = 3'd1;
    localparam logic [2:0] K_READ   = 3'd2;
    localparam logic [2:0] K_RENDER = 3'd3;
    localparam logic [2:0] K_SCROLL = 3'd4;
    localparam int         N_STEPS  = 16;
    localparam logic [31:0] SEED    = 32'd18;

    // kind, address or line, data, dsn, flip, expected readback
    typedef struct packed {
        logic [2:0]  kind;
        logic [10:0] addr;
        logic [15:0] data;
        logic [1:0]  dsn;
        logic        fl;
        logic [15:0] exp;
    } step_t;

    step_t steps [N_STEPS] = '{
        '{K_FILL,   11'h000, 16'h0000, 2'b00, 1'b0, 16'h0000},
        // Scroll row 5 half 0 with each byte-lane pattern
        '{K_WRITE,  11'h7ca, 16'h1234, 2'b00, 1'b0, 16'h0000},
        '{K_READ,   11'h7ca, 16'h0000, 2'b11, 1'b0, 16'h1234},
        '{K_WRITE,  11'h7ca, 16'habcd, 2'b01, 1'b0, 16'h0000},
        '{K_READ,   11'h7ca, 16'h0000, 2'b11, 1'b0, 16'hab34},
        '{K_WRITE,  11'h7ca, 16'h5566, 2'b10, 1'b0, 16'h0000},
        '{K_READ,   11'h7ca, 16'h0000, 2'b11, 1'b0, 16'hab66},
        // Half 1 with the alternate bit set
        '{K_WRITE,  11'h7cb, 16'h83ff, 2'b00, 1'b0, 16'h0000},
        '{K_READ,   11'h7cb, 16'h0000, 2'b11, 1'b0, 16'h83ff},
        '{K_RENDER, 11'd40,  16'h0000, 2'b11, 1'b0, 16'h0000},
        '{K_SCROLL, 11'h000, 16'h0000, 2'b11, 1'b0, 16'h0000},
        '{K_RENDER, 11'd100, 16'h0000, 2'b11, 1'b0, 16'h0000},
        '{K_SCROLL, 11'h000, 16'h0000, 2'b11, 1'b0, 16'h0000},
        '{K_RENDER, 11'd45,  16'h0000, 2'b11, 1'b1, 16'h0000},
        '{K_SCROLL, 11'h000, 16'h0000, 2'b11, 1'b1, 16'h0000},
        '{K_RENDER, 11'd203, 16'h0000, 2'b11, 1'b1, 16'h0000}
    };

    logic        clk;
    logic        rst;
    logic        pxl_cen;
    logic        flip;
    logic [8:0]  hdump;
    logic [8:0]  vrender;
    logic        cpu_cs;
    logic [10:0] cpu_addr;
    logic [15:0] cpu_dout;
    logic [1:0]  dsn;
    logic [15:0] cpu_din;
    logic [12:0] rom_addr;
    logic [31:0] rom_data = 32'd0;
    logic [9:0]  rowscr1;
    logic [9:0]  rowscr2;
    logic        altscr1;
    logic        altscr2;
    logic        scr_start;
    logic [6:0]  pxl;

    // Expected RAM contents kept from the CPU writes
    logic [15:0] shadow [2048];
    logic [8:0]  last_vf;
    int          cycles = 0;
    int          limit;

    char_layer dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Graphics ROM contents hashed from the word address
    function automatic logic [31:0] rom_hash(input logic [12:0] a);
        return xorshift(xorshift(SEED ^ {19'd0, a}));
    endfunction

    function automatic logic [15:0] fill_word(input logic [10:0] a);
        return {a[4:0], a} ^ 16'h3c5a;
    endfunction

    // RAM address of the entry taken at the end of tile k
    function automatic logic [10:0] entry_addr(input logic [5:0] k, input logic [8:0] vf,
                                               input logic fl);
        logic [8:0]  hd;
        logic [8:0]  hf;
        logic [5:0]  col;
        logic [10:0] a;
        // Raw beam on the clock the RAM address is taken
        hd = {k, 3'd7};
        if (hd[8:4] == 5'(`CHAR_ROWREAD)) begin
            // Scroll word used as a tile entry
            a = {5'h1f, vf[7:3], hd[3]};
        end else begin
            hf  = fl ? `CHAR_FLIP_H - {k, 3'd6} : {k, 3'd6};
            col = hf[8:3] + 6'd2;
            a   = {vf[7:3], col};
        end
        return a;
    endfunction

    // Pixel shown while hdump = h from the entry taken three tiles earlier
    function automatic logic [6:0] exp_pixel(input logic [8:0] h, input logic [8:0] vf,
                                             input logic fl);
        logic [15:0] w;
        logic [31:0] rw;
        logic [4:0]  bi;
        w  = shadow[entry_addr(h[8:3] - 6'd3, vf, fl)];
        rw = rom_hash({w[8:0], vf[2:0], 1'b0});
        // Mirrored tiles start from bit 0
        bi = {2'b00, fl ? h[2:0] : 3'd7 - h[2:0]};
        return {w[15], w[11:9], rw[bi + 5'd16], rw[bi + 5'd8], rw[bi]};
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s, got %0h expected %0h", $time, what, got, exp);
            $display("tests failed");
            $fatal(1, "DUT output differs from the expected value");
        end
    endtask

    task automatic cpu_write(input logic [10:0] a, input logic [15:0] d,
                             input logic [1:0] be_n);
        @(negedge clk);
        cpu_cs   = 1'b1;
        cpu_addr = a;
        cpu_dout = d;
        dsn      = be_n;
        if (!be_n[0]) begin
            shadow[a][7:0] = d[7:0];
        end
        if (!be_n[1]) begin
            shadow[a][15:8] = d[15:8];
        end
        @(negedge clk);
        cpu_cs = 1'b0;
        dsn    = 2'b11;
    endtask

    task automatic cpu_read(input logic [10:0] a, input logic [15:0] exp);
        @(negedge clk);
        cpu_addr = a;
        @(negedge clk);
        check(32'(cpu_din), 32'(exp), $sformatf("cpu_din at %0h", a));
    endtask

    // One full line at two clocks per pixel
    task automatic render_line(input logic [8:0] v, input logic fl);
        logic [8:0]  hb;
        logic [8:0]  vf;
        logic [15:0] ent;
        vf = fl ? 9'(`CHAR_FLIP_V) - v : v;
        for (int h = 0; h < 512; h++) begin
            @(negedge clk);
            hb      = 9'(h);
            hdump   = hb;
            vrender = v;
            flip    = fl;
            pxl_cen = 1'b0;
            @(negedge clk);
            // First three tiles still hold the previous line
            if (h >= 24) begin
                check(32'(pxl), 32'(exp_pixel(hb, vf, fl)),
                      $sformatf("pxl at hdump %0d line %0d", h, v));
            end
            // ROM address holds the entry taken at the end of the last tile
            if (h >= 8) begin
                ent = shadow[entry_addr(hb[8:3] - 6'd1, vf, fl)];
                check(32'(rom_addr), 32'({ent[8:0], vf[2:0], 1'b0}),
                      $sformatf("rom_addr at hdump %0d line %0d", h, v));
            end
            // Start level covers the 16 pixels after the read window
            check(32'(scr_start), 32'(h >= 16 * (`CHAR_ROWREAD + 1) &&
                                      h < 16 * (`CHAR_ROWREAD + 2)),
                  $sformatf("scr_start at hdump %0d", h));
            pxl_cen = 1'b1;
        end
        @(negedge clk);
        pxl_cen = 1'b0;
        last_vf = vf;
    endtask

    task automatic scroll_check();
        logic [15:0] h0;
        logic [15:0] h1;
        h0 = shadow[{5'h1f, last_vf[7:3], 1'b0}];
        h1 = shadow[{5'h1f, last_vf[7:3], 1'b1}];
        check(32'(rowscr1), 32'(h0[9:0]), "rowscr1");
        check(32'(altscr1), 32'(h0[15]), "altscr1");
        check(32'(rowscr2), 32'(h1[9:0]), "rowscr2");
        check(32'(altscr2), 32'(h1[15]), "altscr2");
    endtask

    // Run limit from the table length
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("tests failed");
            $fatal(1, "simulation timed out");
        end
    end

    // ROM follows rom_addr on every falling edge
    always @(negedge clk) begin
        rom_data = rom_hash(rom_addr);
    end

    initial begin
        rst      = 1'b1;
        pxl_cen  = 1'b0;
        flip     = 1'b0;
        hdump    = 9'd0;
        vrender  = 9'd0;
        cpu_cs   = 1'b0;
        cpu_addr = 11'd0;
        cpu_dout = 16'd0;
        dsn      = 2'b11;
        last_vf  = 9'd0;
        limit    = 1000;
        for (int i = 0; i < N_STEPS; i++) begin
            case (steps[i].kind)
                K_FILL:   limit += 2 * 2048;
                K_RENDER: limit += 2 * 512;
                default:  limit += 4;
            endcase
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        // Outputs clear out of reset
        check(32'(pxl), 32'd0, "pxl after reset");
        check(32'({altscr1, rowscr1}), 32'd0, "scroll half 0 after reset");
        check(32'({altscr2, rowscr2}), 32'd0, "scroll half 1 after reset");
        for (int i = 0; i < N_STEPS; i++) begin
            case (steps[i].kind)
                K_FILL: begin
                    for (int a = 0; a < 2048; a++) begin
                        cpu_write(11'(a), fill_word(11'(a)), 2'b00);
                    end
                end
                K_WRITE:  cpu_write(steps[i].addr, steps[i].data, steps[i].dsn);
                K_READ:   cpu_read(steps[i].addr, steps[i].exp);
                K_RENDER: render_line(steps[i].addr[8:0], steps[i].fl);
                default:  scroll_check();
            endcase
        end
        $display("all tests passed");
        $finish;
    end

endmodule

/* char_layer.sv */
// ********************
// Character layer top
// RAM, scan, fetch, shifter
// ********************
`include "char_cfg.svh"

module char_layer
    import char_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pxl_cen,
    input  logic                    flip,
    // Beam counters
    input  logic [8:0]              hdump,
    input  logic [8:0]              vrender,
    // CPU access
    input  logic                    cpu_cs,
    input  logic [`CHAR_AW-1:0]     cpu_addr,
    input  logic [`CHAR_DW-1:0]     cpu_dout,
    input  logic [`CHAR_LANES-1:0]  dsn,
    output logic [`CHAR_DW-1:0]     cpu_din,
    // Graphics ROM
    output logic [12:0]             rom_addr,
    input  logic [31:0]             rom_data,
    // Row scroll, exported
    output logic [9:0]              rowscr1,
    output logic [9:0]              rowscr2,
    output logic                    altscr1,
    output logic                    altscr2,
    output logic                    scr_start,
    // Priority, palette, colour
    output logic [CHAR_PXL_W-1:0]   pxl
);

    logic [`CHAR_AW-1:0]                  scan_addr;
    logic [`CHAR_DW-1:0]                  scan_data;
    logic [CHAR_PLANES*CHAR_PLANE_W-1:0]  plane_data;
    logic                                 plane_load;
    char_attr_t                           attr;

    char_tile_if tile_bus ();

    char_vram u_vram (
        .clk       (clk),
        .cpu_addr  (cpu_addr),
        .cpu_dout  (cpu_dout),
        .dsn       (dsn),
        .cpu_cs    (cpu_cs),
        .cpu_din   (cpu_din),
        .scan_addr (scan_addr),
        .scan_data (scan_data)
    );

    char_scan u_scan (
        .clk       (clk),
        .rst       (rst),
        .flip      (flip),
        .hdump     (hdump),
        .vrender   (vrender),
        .scan_addr (scan_addr),
        .scan_data (scan_data),
        .tile      (tile_bus.scan),
        .pxl_cen   (pxl_cen),
        .rowscr1   (rowscr1),
        .rowscr2   (rowscr2),
        .altscr1   (altscr1),
        .altscr2   (altscr2),
        .scr_start (scr_start)
    );

    char_fetch u_fetch (
        .clk        (clk),
        .rst        (rst),
        .tile       (tile_bus.fetch),
        .rom_addr   (rom_addr),
        .rom_data   (rom_data),
        .plane_data (plane_data),
        .plane_load (plane_load),
        .attr       (attr)
    );

    char_shifter u_shifter (
        .clk        (clk),
        .rst        (rst),
        .pxl_cen    (pxl_cen),
        .flip       (flip),
        .plane_data (plane_data),
        .plane_load (plane_load),
        .attr       (attr),
        .pxl        (pxl)
    );

endmodule

/* char_shifter.sv */
// ********************
// Three-plane pixel shifter
// Flip-aware shift, attribute per tile
// ********************
module char_shifter
    import char_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                pxl_cen,
    input  logic                                flip,
    input  logic [CHAR_PLANES*CHAR_PLANE_W-1:0] plane_data,
    input  logic                                plane_load,
    input  char_attr_t                          attr,
    output logic [CHAR_PXL_W-1:0]               pxl
);

    // planes[2] is the colour MSB
    logic [CHAR_PLANES-1:0][CHAR_PLANE_W-1:0] planes;
    logic [CHAR_PLANES-1:0]                   colour;
    char_attr_t                               attr_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            planes <= '0;
            attr_q <= '0;
        end else if (pxl_cen) begin
            if (plane_load) begin
                planes <= plane_data;
                // Attribute switches with the new tile
                attr_q <= attr;
            end else begin
                for (int p = 0; p < CHAR_PLANES; p++) begin
                    // Left for normal, right when mirrored
                    planes[p] <= flip ? planes[p] >> 1 : planes[p] << 1;
                end
            end
        end
    end

    // Outgoing bit of each plane
    always_comb begin
        for (int p = 0; p < CHAR_PLANES; p++) begin
            colour[p] = flip ? planes[p][0] : planes[p][CHAR_PLANE_W-1];
        end
    end

    assign pxl = {attr_q, colour};

endmodule

/* char_fetch.sv */
// ********************
// Graphics ROM fetch
// Code/line hold, plane data and attribute hand-off
// ********************
module char_fetch
    import char_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst,
    char_tile_if.fetch                          tile,
    output logic [12:0]                         rom_addr,
    input  logic [31:0]                         rom_data,
    output logic [CHAR_PLANES*CHAR_PLANE_W-1:0] plane_data,
    output logic                                plane_load,
    output char_attr_t                          attr
);

    logic [8:0] code;
    logic [2:0] line;
    char_attr_t attr_next;

    // Tile being fetched, ROM address held for a whole tile
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            code      <= '0;
            line      <= '0;
            attr_next <= '0;
        end else if (tile.load) begin
            code      <= tile.code;
            line      <= tile.line;
            attr_next <= tile.attr;
        end
    end

    // Bit 0 always clear, ROM word is 32 bits
    assign rom_addr = {code, line, 1'b0};

    // ROM data for the held code, taken as the next tile is captured
    // Attribute moves with it so both reach the shifter together
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            plane_data <= '0;
            attr       <= '0;
        end else if (tile.load) begin
            plane_data <= rom_data[CHAR_PLANES*CHAR_PLANE_W-1:0];
            attr       <= attr_next;
        end
    end

    // Shifter picks up the previous plane_data on this same edge
    assign plane_load = tile.load;

endmodule

/* char_scan.sv */
// ********************
// Beam flip and tilemap scan
// Row-scroll latching, tile entry decode
// ********************
`include "char_cfg.svh"

module char_scan
    import char_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                flip,
    input  logic [8:0]          hdump,
    input  logic [8:0]          vrender,
    output logic [`CHAR_AW-1:0] scan_addr,
    input  logic [`CHAR_DW-1:0] scan_data,
    char_tile_if.scan           tile,
    input  logic                pxl_cen,
    output logic [9:0]          rowscr1,
    output logic [9:0]          rowscr2,
    output logic                altscr1,
    output logic                altscr2,
    output logic                scr_start
);

    logic [8:0] vf;
    logic [8:0] hf;
    logic [5:0] hcol;
    logic       row_win;
    char_word_u word;

    // Flipped beam, one clock behind
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vf <= '0;
            hf <= '0;
        end else begin
            vf <= flip ? 9'(`CHAR_FLIP_V) - vrender : vrender;
            hf <= flip ? `CHAR_FLIP_H - hdump : hdump;
        end
    end

    // Row-scroll window follows the raw beam
    assign row_win   = hdump[8:4] == 5'(`CHAR_ROWREAD);
    assign scr_start = hdump[8:4] == 5'(`CHAR_ROWREAD + 1);

    // Two tiles ahead of the beam
    assign hcol = hf[8:3] + 6'd2;

    // Tilemap row/column, or scroll table entry in the window
    assign scan_addr = row_win ? {`CHAR_SCR_PAGE, vf[7:3], hdump[3]}
                               : {vf[7:3], hcol};

    assign word = scan_data;

    // Scroll view: half 0 then half 1
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rowscr1 <= '0;
            rowscr2 <= '0;
            altscr1 <= 1'b0;
            altscr2 <= 1'b0;
        end else if (row_win) begin
            if (!hdump[3]) begin
                rowscr1 <= word.scroll.value;
                altscr1 <= word.scroll.alt;
            end else begin
                rowscr2 <= word.scroll.value;
                altscr2 <= word.scroll.alt;
            end
        end
    end

    // Tile view, taken by fetch on the strobe
    assign tile.code      = word.tile.code;
    assign tile.line      = vf[2:0];
    assign tile.attr.prio = word.tile.prio;
    assign tile.attr.pal  = word.tile.pal;
    // Last pixel of the current tile
    assign tile.load      = pxl_cen && (hdump[2:0] == 3'd7);

endmodule

/* char_vram.sv */
// ********************
// Character RAM, 2K x 16 dual port
// CPU byte writes and readback, video read
// ********************
`include "char_cfg.svh"

module char_vram (
    input  logic                    clk,
    // CPU side
    input  logic [`CHAR_AW-1:0]     cpu_addr,
    input  logic [`CHAR_DW-1:0]     cpu_dout,
    input  logic [`CHAR_LANES-1:0]  dsn,
    input  logic                    cpu_cs,
    output logic [`CHAR_DW-1:0]     cpu_din,
    // Video side
    input  logic [`CHAR_AW-1:0]     scan_addr,
    output logic [`CHAR_DW-1:0]     scan_data
);

    logic [`CHAR_DW-1:0]    mem [0:(1 << `CHAR_AW) - 1];
    logic [`CHAR_LANES-1:0] we;

    // Byte enables are active low
    assign we = ~dsn & {`CHAR_LANES{cpu_cs}};

    // CPU port, write first per lane
    always_ff @(posedge clk) begin
        for (int b = 0; b < `CHAR_LANES; b++) begin
            if (we[b]) begin
                mem[cpu_addr][8*b +: 8] <= cpu_dout[8*b +: 8];
                // Readback shows the new byte at once
                cpu_din[8*b +: 8]       <= cpu_dout[8*b +: 8];
            end else begin
                cpu_din[8*b +: 8]       <= mem[cpu_addr][8*b +: 8];
            end
        end
    end

    // Video port, read only
    // Same-address collision returns old data
    always_ff @(posedge clk) begin
        scan_data <= mem[scan_addr];
    end

endmodule

/* char_tile_if.sv */
// ********************
// Tile hand-off bus
// Scan stage to fetch stage
// ********************
interface char_tile_if;
    import char_pkg::*;

    // Tile code from the tilemap
    logic [8:0] code;
    // Line inside the tile, already flipped
    logic [2:0] line;
    char_attr_t attr;
    // One clock, last pixel of each tile
    logic       load;

    modport scan (
        output code,
        output line,
        output attr,
        output load
    );

    modport fetch (
        input code,
        input line,
        input attr,
        input load
    );

endinterface

/* char_pkg.sv */
// ********************
// Character layer types
// RAM word union, attribute, pixel widths
// ********************
package char_pkg;

    // Bit-planes per pixel and plane width
    localparam int CHAR_PLANES  = 3;
    localparam int CHAR_PLANE_W = 8;

    // Priority plus palette, travels with each tile
    typedef struct packed {
        logic       prio;
        logic [2:0] pal;
    } char_attr_t;

    // Output pixel: attribute then colour bits
    localparam int CHAR_PXL_W = $bits(char_attr_t) + CHAR_PLANES;

    // Tilemap view of a RAM word
    typedef struct packed {
        logic       prio;
        logic [2:0] spare;
        logic [2:0] pal;
        logic [8:0] code;
    } char_tile_t;

    // Row-scroll table view of a RAM word
    typedef struct packed {
        logic       alt;
        logic [4:0] spare;
        logic [9:0] value;
    } char_scroll_t;

    // Same word, meaning depends on the scan window
    typedef union packed {
        char_tile_t   tile;
        char_scroll_t scroll;
    } char_word_u;

endpackage

/* char_cfg.svh */
// ********************
// Character layer constants
// RAM geometry, row-scroll window, flip offsets
// ********************
`ifndef CHAR_CFG_SVH
`define CHAR_CFG_SVH

// Character RAM word address width, 2K words
`define CHAR_AW 11
// Character RAM word width and byte lanes
`define CHAR_DW 16
`define CHAR_LANES (`CHAR_DW / 8)

// hdump[8:4] value of the row-scroll read window
`define CHAR_ROWREAD 8
// Page holding the row-scroll table
`define CHAR_SCR_PAGE 5'h1f

// Visible lines and flip offsets
`define CHAR_VLINES 224
`define CHAR_FLIP_V (`CHAR_VLINES - 1)
`define CHAR_FLIP_H 9'ha3

`endif
